// File: Makefile
# Verilator build and run of the register file slice testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --top-module aexmRegfTb -f build.f -Mdir obj_dir -o simv

# The run passes only if the log holds the pass line
run: compile
	./obj_dir/simv | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: aexmRegf.sv
/* Register file slice top */

`timescale 1ns/1ps

module aexmRegf import aexmRegfPkg::*; (
   input  logic    gclk,
   input  logic    grst,
   input  logic    gena,
   // Operand reads
   input  regAddr  rdA,
   input  regAddr  rdB,
   output word     regA,
   output word     regB,
   // Writeback request
   input  wbReq    wb,
   // Store request
   input  storeReq store,
   // Load data from the cache
   input  laneSel  lane,
   input  word     cacheIn,
   output word     loadData,
   // Store data to the cache
   output word     cacheOut
);

   // Bank to store path
   logic wbEn;
   word  wbData;
   word  regD;

   // Load aligner, feeds the bank and the port
   loadAlign uLoad (
      .lane     (lane),
      .cacheIn  (cacheIn),
      .loadData (loadData)
   );

   // Register bank, store source read with the store register
   gprBank uBank (
      .gclk     (gclk),
      .grst     (grst),
      .rdA      (rdA),
      .rdB      (rdB),
      .wb       (wb),
      .loadData (loadData),
      .storeReg (store.storeReg),
      .regA     (regA),
      .regB     (regB),
      .regD     (regD),
      .wbEn     (wbEn),
      .wbData   (wbData)
   );

   // Store aligner with forwarding from the writeback
   storeAlign uStore (
      .gclk      (gclk),
      .grst      (grst),
      .gena      (gena),
      .store     (store),
      .writeAddr (wb.writeAddr),
      .wbEn      (wbEn),
      .wbData    (wbData),
      .regD      (regD),
      .cacheOut  (cacheOut)
   );

endmodule

// File: aexmRegfPkg.sv
/* Register file types */

package aexmRegfPkg;

`include "aexmRegf_defines.svh"

   // One data word
   typedef logic [`WORD_W-1:0] word;

   // Register number, R0 reads as zero
   typedef logic [`ADDR_W-1:0] regAddr;

   // One bit per byte lane of a word
   typedef logic [`WORD_W/8-1:0] laneSel;

   // Writeback source code, see WB_* macros
   typedef logic [1:0] wbSrc;

   // Store size code, see SZ_* macros
   typedef logic [1:0] accSize;

   // Link address without the two zero bits at the bottom
   typedef logic [`WORD_W-1:2] pcWord;

   // Writeback request from the end of the pipe
   typedef struct packed {
      regAddr writeAddr;
      wbSrc   src;
      word    result;
      pcWord  link;
   } wbReq;

   // Store request, register to read and how wide
   typedef struct packed {
      regAddr storeReg;
      accSize size;
   } storeReq;

endpackage

// File: aexmRegfTb.sv
/* Register file slice testbench */

`timescale 1ns/1ps
`include "aexmRegf_defines.svh"

module aexmRegfTb import aexmRegfPkg::*; ();

   localparam int CLK_PERIOD = 40;
   // Cycle counts of the test loops
   localparam int LOAD_N = 32;
   localparam int RAND_N = 60;
   localparam int ZERO_N = 10;
   localparam int STORE_N = 80;
   localparam int ENA_N = 30;
   // Reset twice, fill the bank, loops, and the closing cycles of five tests
   localparam int TEST_CYCLES = 6 + `REG_N + LOAD_N + RAND_N + ZERO_N + STORE_N + ENA_N + 15;

   // Clock starts low without an edge at time zero
   logic    gclk = 1'b0;
   logic    grst;
   logic    gena;
   regAddr  rdA;
   regAddr  rdB;
   word     regA;
   word     regB;
   wbReq    wb;
   storeReq store;
   laneSel  lane;
   word     cacheIn;
   word     loadData;
   word     cacheOut;

   // Shadow register bank and the expected cache word
   word shadow [`REG_N];
   word expCache = '0;

   logic [31:0] lcgState = 32'h1568_b15d;
   int errorCount = 0;
   int checkCount = 0;
   int testNum = 0;
   int testStart = 0;

   // Seven legal lane selects, then one that is not
   laneSel laneCodes [8] = '{4'h8, 4'h4, 4'h2, 4'h1, 4'hC, 4'h3, 4'hF, 4'h6};

   aexmRegf dut (
      .gclk     (gclk),
      .grst     (grst),
      .gena     (gena),
      .rdA      (rdA),
      .rdB      (rdB),
      .regA     (regA),
      .regB     (regB),
      .wb       (wb),
      .store    (store),
      .lane     (lane),
      .cacheIn  (cacheIn),
      .loadData (loadData),
      .cacheOut (cacheOut)
   );

   initial begin
      forever #(CLK_PERIOD / 2) gclk = ~gclk;
   end

   // Linear congruential generator
   function automatic logic [31:0] lcgNext();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Expected load data zero extended from the selected lanes
   function automatic word loadRef(laneSel sel, word data);
      word res;
      res = '0;
      case (sel)
         4'b0001: res[7:0] = data[7:0];
         4'b0010: res[7:0] = data[15:8];
         4'b0100: res[7:0] = data[23:16];
         4'b1000: res[7:0] = data[31:24];
         4'b0011: res[15:0] = data[15:0];
         4'b1100: res[15:0] = data[31:16];
         4'b1111: res = data;
         default: res = '0;
      endcase
      return res;
   endfunction

   // Expected store word replicated by size
   function automatic word storeRef(accSize sz, word data);
      word res;
      case (sz)
         `SZ_BYTE: res = {data[7:0], data[7:0], data[7:0], data[7:0]};
         `SZ_HALF: res = {data[15:0], data[15:0]};
         `SZ_WORD: res = data;
         default:  res = '0;
      endcase
      return res;
   endfunction

   // Expected writeback value
   function automatic word wbRef(wbReq req, word loadVal, word oldVal);
      word res;
      case (req.src)
         `WB_RESULT: res = req.result;
         `WB_LINK:   res = {req.link, 2'b00};
         `WB_LOAD:   res = loadVal;
         default:    res = oldVal;
      endcase
      return res;
   endfunction

   task automatic checkWord(string what, word got, word exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Comparison at the falling edge, then the model steps to the next rising edge
   initial begin : compare
      word wbVal;
      word srcVal;
      forever begin
         @(negedge gclk);
         if (grst) begin
            shadow[0] = '0;
            expCache = '0;
         end else begin
            checkWord("loadData", loadData, loadRef(lane, cacheIn));
            checkWord("regA", regA, shadow[rdA]);
            checkWord("regB", regB, shadow[rdB]);
            checkWord("cacheOut", cacheOut, expCache);
            wbVal = wbRef(wb, loadRef(lane, cacheIn), shadow[wb.writeAddr]);
            // Store source written this cycle takes the new value
            if (wb.writeAddr != 0 && store.storeReg == wb.writeAddr) begin
               srcVal = wbVal;
            end else begin
               srcVal = shadow[store.storeReg];
            end
            if (gena) begin
               expCache = storeRef(store.size, srcVal);
            end
            if (wb.writeAddr != 0) begin
               shadow[wb.writeAddr] = wbVal;
            end
         end
      end
   end

   task automatic setIdle();
      wb.writeAddr <= '0;
      wb.src <= `WB_RESULT;
      wb.result <= '0;
      wb.link <= '0;
      store.storeReg <= '0;
      store.size <= `SZ_WORD;
      rdA <= '0;
      rdB <= '0;
      lane <= 4'hF;
      cacheIn <= '0;
      gena <= 1'b1;
   endtask

   task automatic applyReset();
      grst <= 1'b1;
      repeat (3) @(posedge gclk);
      grst <= 1'b0;
   endtask

   // Random writeback to a nonzero register, with random load data
   task automatic randomWb(input wbSrc src, output regAddr addr);
      logic [31:0] r;
      r = lcgNext();
      addr = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
      wb.writeAddr <= addr;
      wb.src <= src;
      wb.result <= lcgNext();
      cacheIn <= lcgNext();
      r = lcgNext();
      wb.link <= r[31:2];
      lane <= laneCodes[r[2:0]];
   endtask

   // Idle cycle so the last store is compared, then the summary line
   task automatic endTest(string name);
      @(posedge gclk);
      setIdle();
      @(negedge gclk);
      #1;
      testNum++;
      $display("Test %0d, %s: %0d errors", testNum, name, errorCount - testStart);
      testStart = errorCount;
   endtask

   initial begin : stimulus
      int i;
      regAddr addr;
      regAddr lastAddr;
      logic [31:0] r;
      setIdle();
      applyReset();

      for (i = 0; i < LOAD_N; i++) begin
         @(posedge gclk);
         lane <= laneCodes[i[2:0]];
         cacheIn <= lcgNext();
      end
      endTest("load alignment");

      // Fill every register, reading back the one written a cycle before
      for (i = 1; i < `REG_N; i++) begin
         @(posedge gclk);
         wb.writeAddr <= regAddr'(i);
         wb.src <= `WB_RESULT;
         wb.result <= lcgNext();
         rdA <= regAddr'(i - 1);
      end
      lastAddr = regAddr'(`REG_N - 1);
      for (i = 0; i < RAND_N; i++) begin
         @(posedge gclk);
         r = lcgNext();
         rdA <= lastAddr;
         rdB <= r[9:5];
         randomWb(r[1:0], addr);
         lastAddr = addr;
      end
      endTest("writeback and read");

      @(posedge gclk);
      applyReset();
      for (i = 0; i < ZERO_N; i++) begin
         @(posedge gclk);
         r = lcgNext();
         wb.writeAddr <= '0;
         wb.src <= (r[1:0] == `WB_KEEP) ? `WB_RESULT : r[1:0];
         wb.result <= lcgNext();
         wb.link <= r[31:2];
      end
      endTest("register 0");

      // Every other store on average reads the register being written
      for (i = 0; i < STORE_N; i++) begin
         @(posedge gclk);
         r = lcgNext();
         randomWb(r[1:0], addr);
         store.size <= r[3:2];
         if (r[4]) begin
            store.storeReg <= addr;
         end else begin
            store.storeReg <= r[9:5];
         end
      end
      endTest("store alignment and forwarding");

      for (i = 0; i < ENA_N; i++) begin
         @(posedge gclk);
         r = lcgNext();
         gena <= (i % 3 == 2);
         rdA <= lastAddr;
         randomWb(r[1:0], addr);
         lastAddr = addr;
         store.size <= r[3:2];
         store.storeReg <= r[9:5];
      end
      endTest("enable");

      $display("Done: %0d tests, %0d checks, %0d errors", testNum, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin : watchdog
      #((TEST_CYCLES + 20) * CLK_PERIOD);
      $display("Timeout: tests did not finish within %0d cycles", TEST_CYCLES + 20);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: aexmRegf_defines.svh
/* Register file widths and codes */

`ifndef AEXMREGF_DEFINES_SVH
`define AEXMREGF_DEFINES_SVH

// Data path width in bits
`define WORD_W 32

// General purpose register count, R0 included
`define REG_N 32

// Register number width, enough for REG_N entries
`define ADDR_W 5

// Writeback source select
// Result comes from the ALU
`define WB_RESULT 2'd0
// Link is the saved return address
`define WB_LINK 2'd1
// Load is the aligned cache read data
`define WB_LOAD 2'd2
// Keep rewrites the destination with itself
`define WB_KEEP 2'd3

// Store access size, taken from the low opcode bits
`define SZ_BYTE 2'd0
`define SZ_HALF 2'd1
`define SZ_WORD 2'd2

`endif

// File: build.f
+incdir+.
aexmRegfPkg.sv
loadAlign.sv
gprBank.sv
storeAlign.sv
aexmRegf.sv
aexmRegfTb.sv

// File: gprBank.sv
/* General purpose register bank */

`timescale 1ns/1ps
`include "aexmRegf_defines.svh"

module gprBank import aexmRegfPkg::*; (
   input  logic   gclk,
   input  logic   grst,
   // Operand read ports
   input  regAddr rdA,
   input  regAddr rdB,
   // Writeback request and load source
   input  wbReq   wb,
   input  word    loadData,
   // Store source read port
   input  regAddr storeReg,
   output word    regA,
   output word    regB,
   output word    regD,
   // Writeback toward the store forwarding path
   output logic   wbEn,
   output word    wbData
);

   // Register storage, R0 to R31
   word regs [`REG_N];

   // Current content of the destination, used by keep
   word regW;

   // Link value widened back to a full byte address
   word linkAddr;

   // Asynchronous reads, three ports plus the destination
   assign regA = regs[rdA];
   assign regB = regs[rdB];
   assign regD = regs[storeReg];
   assign regW = regs[wb.writeAddr];

   // Link is word aligned, append the dropped zero bits
   assign linkAddr = {wb.link, 2'b00};

   // Destination R0 means no writeback this cycle
   assign wbEn = |wb.writeAddr;

   // Pick the value to write back
   always_comb begin
      case (wb.src)
         `WB_RESULT: wbData = wb.result;
         `WB_LINK:   wbData = linkAddr;
         `WB_LOAD:   wbData = loadData;
         // Keep writes the old value back, no visible change
         `WB_KEEP:   wbData = regW;
         default:    wbData = '0;
      endcase
   end

   // Write port
   // R0 is cleared in reset and the enable never selects it later
   always_ff @(posedge gclk) begin
      if (grst) begin
         regs[0] <= '0;
      end else if (wbEn) begin
         // Writeback ignores the pipeline enable
         regs[wb.writeAddr] <= wbData;
      end
   end

endmodule

// File: loadAlign.sv
/* Load data aligner */

`timescale 1ns/1ps

module loadAlign import aexmRegfPkg::*; (
   input  laneSel lane,
   input  word    cacheIn,
   output word    loadData
);

   // Byte lanes of the cache word, lane 3 is the most significant
   logic [7:0] byte3;
   logic [7:0] byte2;
   logic [7:0] byte1;
   logic [7:0] byte0;

   // Halfword lanes
   logic [15:0] halfHi;
   logic [15:0] halfLo;

   // Split the incoming word once, the case below only picks
   assign byte3  = cacheIn[31:24];
   assign byte2  = cacheIn[23:16];
   assign byte1  = cacheIn[15:8];
   assign byte0  = cacheIn[7:0];
   assign halfHi = cacheIn[31:16];
   assign halfLo = cacheIn[15:0];

   // Lane select is one-hot for bytes, paired for halves, full for words
   always_comb begin
      case (lane)
         // Single byte loads
         4'h8: loadData = {24'd0, byte3};
         4'h4: loadData = {24'd0, byte2};
         4'h2: loadData = {24'd0, byte1};
         4'h1: loadData = {24'd0, byte0};
         // Halfword loads, big-endian upper half first
         4'hC: loadData = {16'd0, halfHi};
         4'h3: loadData = {16'd0, halfLo};
         // Whole word
         4'hF: loadData = cacheIn;
         // Misaligned or empty select returns zero
         default: loadData = '0;
      endcase
   end

endmodule

// File: storeAlign.sv
/* Store data aligner */

`timescale 1ns/1ps
`include "aexmRegf_defines.svh"

module storeAlign import aexmRegfPkg::*; (
   input  logic    gclk,
   input  logic    grst,
   input  logic    gena,
   // Store request
   input  storeReq store,
   // Writeback in flight, for forwarding
   input  regAddr  writeAddr,
   input  logic    wbEn,
   input  word     wbData,
   // Register value of the store source
   input  word     regD,
   // Registered word toward the data cache
   output word     cacheOut
);

   // Store source collides with the register written this cycle
   logic fwdHit;

   // Store data after forwarding
   word srcData;

   // Store data replicated over the lanes
   word laneData;

   // Bank read still shows the old value until the edge,
   // so take the writeback value on a match
   assign fwdHit  = wbEn && (store.storeReg == writeAddr);
   assign srcData = fwdHit ? wbData : regD;

   // Copy the low part into every lane, the cache strobes pick one
   always_comb begin
      case (store.size)
         // Byte in all four lanes
         `SZ_BYTE: laneData = {4{srcData[7:0]}};
         // Halfword in both halves
         `SZ_HALF: laneData = {2{srcData[15:0]}};
         // Word as is
         `SZ_WORD: laneData = srcData;
         // Unknown size sends zero
         default:  laneData = '0;
      endcase
   end

   // Output register, held while the pipe is stalled
   always_ff @(posedge gclk) begin
      if (grst) begin
         cacheOut <= '0;
      end else if (gena) begin
         cacheOut <= laneData;
      end
   end

endmodule
